// ==== nes_bridge.f ====
verilog/pocket_pkg.sv
verilog/bridge_decode.sv
verilog/settings_regs.sv
verilog/save_buffer.sv
verilog/video_condition.sv
verilog/nes_bridge_top.sv
bench/tb_nes_bridge.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_nes_bridge
FILELIST  := nes_bridge.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_nes_bridge.sv ====
// testbench for the bridge-facing NES top level
// xorshift driven bridge and video stimulus, checked every cycle
// against a behavioral model of the settings, save buffer and video stage

`timescale 1ns/10ps

module tb_nes_bridge
  import pocket_pkg::*;
();

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_LEN    = 5;
  localparam int SETTINGS_LEN = 3000;
  localparam int HOLD_LEN     = 2000;
  localparam int SAVE_LEN     = 3000;
  localparam int UNMAPPED_LEN = 1000;
  localparam int VIDEO_LEN    = 4000;
  localparam int PHASE_SUM    = RESET_LEN + SETTINGS_LEN + HOLD_LEN + SAVE_LEN
                                + UNMAPPED_LEN + VIDEO_LEN;
  localparam int WATCHDOG_CYCLES = 2 * PHASE_SUM + RESET_HOLD_CYCLES;
  // savestate region of the full core is unmapped here
  localparam logic [REGION_W-1:0] REGION_SAVESTATE = 4'h4;

  logic clk_74a, pll_core_locked, bridge_rd, bridge_wr;
  logic [BRIDGE_W-1:0] bridge_addr, bridge_wr_data, bridge_rd_data;
  logic hide_overscan, allow_extra_sprites, multitap_enabled, lightgun_enabled;
  logic swap_controllers, external_reset;
  logic [EDGE_MASK_W-1:0] mask_vid_edges;
  logic [PALETTE_W-1:0]   selected_palette;
  logic [AIM_SPEED_W-1:0] lightgun_dpad_aim_speed;
  logic h_blank, v_blank, hsync_in, vsync_in, video_de, video_hs, video_vs;
  logic [RGB_W-1:0] rgb_in, video_rgb;

  ////////////////////////////////////////
  // reference model state
  logic m_overscan, m_sprites, m_multitap, m_lightgun, m_swap;
  logic [EDGE_MASK_W-1:0] m_edges;
  logic [PALETTE_W-1:0]   m_palette;
  logic [AIM_SPEED_W-1:0] m_aim;
  int                     m_reset_cnt;
  logic [BRIDGE_W-1:0]    m_mem [SAVE_WORDS];
  bit                     m_written [SAVE_WORDS];
  logic [BRIDGE_W-1:0]    m_rd_data;
  logic m_hs_prev, m_vs_prev, m_de_prev, m_hs_armed;
  int                     m_hs_age;
  logic m_de, m_hs, m_vs;
  logic [RGB_W-1:0]       m_rgb;
  logic [31:0]            rng_state = 32'd74;
  cfg_reg_t               cfg_list [9];

  nes_bridge_top dut_i (.*);

  initial begin
    clk_74a = 1'b0;
    forever #(CLK_PERIOD / 2) clk_74a = ~clk_74a;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock periods", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [BRIDGE_W-1:0] make_addr(input logic [REGION_W-1:0] region,
      input logic [15:0] mid, input logic [CFG_OFFSET_W-1:0] offset);
    return {region, mid, offset};
  endfunction

  function automatic logic [BRIDGE_W-1:0] save_addr(input logic [SAVE_ADDR_W-1:0] idx,
      input logic [31:0] extra);
    return {REGION_SAVE, extra[27:10], idx, extra[1:0]};
  endfunction

  // never the config or save region
  function automatic logic [REGION_W-1:0] unmapped_region(input logic [REGION_W-1:0] r);
    if (r == REGION_CFG || r == REGION_SAVE) begin
      return r + 4'd1;
    end
    return r;
  endfunction

  task automatic compare_word(input string name, input logic [BRIDGE_W-1:0] got,
      input logic [BRIDGE_W-1:0] exp);
    if (got !== exp) begin
      $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic compare_rgb(input string name, input logic [RGB_W-1:0] got,
      input logic [RGB_W-1:0] exp);
    if (got !== exp) begin
      $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail at %0d ns: %s is %b, expected %b", $time, name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  ////////////////////////////////////////
  // model step using the inputs sampled at this edge
  task automatic update_model();
    logic [REGION_W-1:0]     region;
    logic [CFG_OFFSET_W-1:0] offset;
    logic [SAVE_ADDR_W-1:0]  idx;
    logic [RGB_W-1:0]        slot;
    logic                    de_in;
    region = bridge_addr[31:28];
    offset = bridge_addr[11:0];
    idx    = bridge_addr[9:2];
    de_in  = !(h_blank || v_blank);
    if (!pll_core_locked) begin
      {m_overscan, m_sprites, m_multitap, m_lightgun, m_swap} = '0;
      m_edges     = '0;
      m_palette   = '0;
      m_aim       = '0;
      m_reset_cnt = 0;
      m_rd_data   = '0;
      {m_hs_prev, m_vs_prev, m_de_prev, m_hs_armed, m_de, m_hs, m_vs} = '0;
      m_hs_age    = 0;
      m_rgb       = '0;
    end else begin
      // video goes first so the slot word sees the setting held before this edge
      slot     = '0;
      slot[13] = m_overscan;
      m_de     = de_in;
      m_rgb    = de_in ? rgb_in : (m_de_prev ? slot : '0);
      m_hs     = m_hs_armed && (m_hs_age == HS_DELAY - 1);
      if (!m_hs_prev && hsync_in) begin
        m_hs_armed = 1'b1;
        m_hs_age   = 0;
      end else if (m_hs_armed) begin
        if (m_hs_age == HS_DELAY - 1) m_hs_armed = 1'b0;
        else m_hs_age = m_hs_age + 1;
      end
      m_vs      = !m_vs_prev && vsync_in;
      m_hs_prev = hsync_in;
      m_vs_prev = vsync_in;
      m_de_prev = de_in;
      if (bridge_wr && region == REGION_CFG) begin
        case (offset)
          REG_OVERSCAN:      m_overscan = bridge_wr_data[0];
          REG_VID_EDGES:     m_edges    = bridge_wr_data[EDGE_MASK_W-1:0];
          REG_EXTRA_SPRITES: m_sprites  = bridge_wr_data[0];
          REG_PALETTE:       m_palette  = bridge_wr_data[PALETTE_W-1:0];
          REG_MULTITAP:      m_multitap = bridge_wr_data[0];
          REG_LIGHTGUN:      m_lightgun = bridge_wr_data[0];
          REG_AIM_SPEED:     m_aim      = bridge_wr_data[AIM_SPEED_W-1:0];
          REG_SWAP_CONT:     m_swap     = bridge_wr_data[0];
          default: ;
        endcase
      end
      if (bridge_wr && region == REGION_CFG && offset == REG_RESET) begin
        m_reset_cnt = RESET_HOLD_CYCLES;
      end else if (m_reset_cnt > 0) begin
        m_reset_cnt = m_reset_cnt - 1;
      end
      if (bridge_wr && region == REGION_SAVE) begin
        m_mem[idx]     = bridge_wr_data;
        m_written[idx] = 1'b1;
      end
      if (bridge_rd) begin
        m_rd_data = (region == REGION_SAVE) ? m_mem[idx] : '0;
      end
    end
  endtask

  task automatic check_outputs();
    compare_word("bridge_rd_data", bridge_rd_data, m_rd_data);
    compare_bit("hide_overscan", hide_overscan, m_overscan);
    compare_word("mask_vid_edges", BRIDGE_W'(mask_vid_edges), BRIDGE_W'(m_edges));
    compare_bit("allow_extra_sprites", allow_extra_sprites, m_sprites);
    compare_word("selected_palette", BRIDGE_W'(selected_palette), BRIDGE_W'(m_palette));
    compare_bit("multitap_enabled", multitap_enabled, m_multitap);
    compare_bit("lightgun_enabled", lightgun_enabled, m_lightgun);
    compare_word("lightgun_dpad_aim_speed", BRIDGE_W'(lightgun_dpad_aim_speed),
                 BRIDGE_W'(m_aim));
    compare_bit("swap_controllers", swap_controllers, m_swap);
    compare_bit("external_reset", external_reset, m_reset_cnt != 0);
    compare_bit("video_de", video_de, m_de);
    compare_bit("video_hs", video_hs, m_hs);
    compare_bit("video_vs", video_vs, m_vs);
    compare_rgb("video_rgb", video_rgb, m_rgb);
  endtask

  // one clock with the model update at the edge and the check once outputs settle
  task automatic advance_clock();
    @(posedge clk_74a);
    update_model();
    #1;
    check_outputs();
  endtask

  task automatic host_write(input logic [BRIDGE_W-1:0] addr, input logic [BRIDGE_W-1:0] data);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    advance_clock();
    bridge_wr = 1'b0;
  endtask

  task automatic host_read(input logic [BRIDGE_W-1:0] addr);
    bridge_addr = addr;
    bridge_rd   = 1'b1;
    advance_clock();
    bridge_rd = 1'b0;
  endtask

  // address and data are don't care without a strobe
  task automatic host_idle();
    bridge_addr    = rand32();
    bridge_wr_data = rand32();
    advance_clock();
  endtask

  ////////////////////////////////////////
  // test phases
  task automatic run_settings_phase();
    logic [31:0] r;
    logic [31:0] d;
    repeat (SETTINGS_LEN) begin
      r = rand32();
      d = rand32();
      case (r[2:0])
        3'd1, 3'd2, 3'd3: host_write(make_addr(REGION_CFG, r[31:16], cfg_list[r[7:4] % 4'd9]), d);
        3'd4: host_write(make_addr(REGION_CFG, r[31:16], d[27:16]), d);
        3'd5: host_write(make_addr(unmapped_region(r[11:8]), r[31:16],
                                   cfg_list[r[7:4] % 4'd9]), d);
        3'd6: host_read(make_addr(REGION_CFG, r[31:16], cfg_list[r[7:4] % 4'd9]));
        default: host_idle();
      endcase
    end
  endtask

  task automatic run_hold_phase();
    logic [31:0] r;
    repeat (HOLD_LEN) begin
      r = rand32();
      if (r[6:0] == 7'd0) host_write(make_addr(REGION_CFG, r[31:16], REG_RESET), rand32());
      else host_idle();
    end
  endtask

  task automatic run_save_phase();
    logic [31:0] r;
    logic [31:0] a;
    repeat (SAVE_LEN) begin
      r = rand32();
      a = rand32();
      if (r[1:0] == 2'd0) host_idle();
      else if (r[1:0] == 2'd1 || !m_written[r[15:8]]) host_write(save_addr(r[15:8], a), rand32());
      else host_read(save_addr(r[15:8], a));
    end
  endtask

  task automatic run_unmapped_phase();
    logic [31:0] r;
    logic [31:0] a;
    repeat (UNMAPPED_LEN) begin
      r = rand32();
      a = rand32();
      case (r[1:0])
        2'd0: host_read(make_addr(REGION_CFG, a[15:0], a[27:16]));
        2'd1: host_read(make_addr(REGION_SAVESTATE, a[15:0], a[27:16]));
        2'd2: host_read(make_addr(unmapped_region(a[31:28]), a[15:0], a[27:16]));
        default: begin
          // a save read in between makes the zero a real change
          if (m_written[r[15:8]]) host_read(save_addr(r[15:8], a));
          else host_idle();
        end
      endcase
    end
  endtask

  task automatic run_video_phase();
    logic [31:0] r;
    logic [31:0] d;
    logic        ovs;
    ovs = 1'b0;
    repeat (2) begin
      d    = rand32();
      d[0] = ovs;
      host_write(make_addr(REGION_CFG, 16'h0000, REG_OVERSCAN), d);
      repeat (VIDEO_LEN / 2) begin
        r = rand32();
        d = rand32();
        if (r[2:0] == 3'd0) h_blank = !h_blank;
        if (r[7:3] == 5'd0) v_blank = !v_blank;
        // frequent toggles put new rising edges inside the hs window
        if (r[9:8] == 2'd0) hsync_in = !hsync_in;
        if (r[13:10] == 4'd0) vsync_in = !vsync_in;
        rgb_in = d[RGB_W-1:0];
        host_idle();
      end
      ovs = 1'b1;
    end
  endtask

  task automatic run_final_hold();
    int held;
    held = 0;
    host_write(make_addr(REGION_CFG, 16'h0000, REG_RESET), rand32());
    while (external_reset) begin
      held = held + 1;
      host_idle();
    end
    compare_word("external_reset hold length", BRIDGE_W'(held), BRIDGE_W'(RESET_HOLD_CYCLES));
    repeat (8) host_idle();
  endtask

  initial begin
    cfg_list = '{REG_RESET, REG_OVERSCAN, REG_VID_EDGES, REG_EXTRA_SPRITES, REG_PALETTE,
                 REG_MULTITAP, REG_LIGHTGUN, REG_AIM_SPEED, REG_SWAP_CONT};
    pll_core_locked = 1'b1;
    bridge_addr     = '0;
    bridge_rd       = 1'b0;
    bridge_wr       = 1'b0;
    bridge_wr_data  = '0;
    h_blank         = 1'b1;
    v_blank         = 1'b1;
    hsync_in        = 1'b0;
    vsync_in        = 1'b0;
    rgb_in          = '0;
    #1;
    pll_core_locked = 1'b0;
    repeat (RESET_LEN) advance_clock();
    pll_core_locked = 1'b1;
    run_settings_phase();
    run_hold_phase();
    run_save_phase();
    run_unmapped_phase();
    run_video_phase();
    run_final_hold();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== verilog/nes_bridge_top.sv ====
// bridge-facing top level of the NES core
// host bridge decode, settings registers, save buffer and video conditioning
// all logic runs on clk_74a and resets while pll_core_locked is low

`timescale 1ns/10ps

module nes_bridge_top
  import pocket_pkg::*;
(
  input  logic                   clk_74a,
  input  logic                   pll_core_locked,
  // host bridge
  input  logic [BRIDGE_W-1:0]    bridge_addr,
  input  logic                   bridge_rd,
  input  logic                   bridge_wr,
  input  logic [BRIDGE_W-1:0]    bridge_wr_data,
  output logic [BRIDGE_W-1:0]    bridge_rd_data,
  // settings toward the core
  output logic                   hide_overscan,
  output logic [EDGE_MASK_W-1:0] mask_vid_edges,
  output logic                   allow_extra_sprites,
  output logic [PALETTE_W-1:0]   selected_palette,
  output logic                   multitap_enabled,
  output logic                   lightgun_enabled,
  output logic [AIM_SPEED_W-1:0] lightgun_dpad_aim_speed,
  output logic                   swap_controllers,
  output logic                   external_reset,
  // core video
  input  logic                   h_blank,
  input  logic                   v_blank,
  input  logic                   hsync_in,
  input  logic                   vsync_in,
  input  logic [RGB_W-1:0]       rgb_in,
  // scaler
  output logic                   video_de,
  output logic                   video_hs,
  output logic                   video_vs,
  output logic [RGB_W-1:0]       video_rgb
);

  logic                cfg_wr;
  logic                save_wr;
  logic                save_rd;
  logic [BRIDGE_W-1:0] save_q;

  ////////////////////////////////////////
  // bridge side
  bridge_decode decode_i (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge_addr     (bridge_addr),
    .bridge_rd       (bridge_rd),
    .bridge_wr       (bridge_wr),
    .save_q          (save_q),
    .cfg_wr          (cfg_wr),
    .save_wr         (save_wr),
    .save_rd         (save_rd),
    .bridge_rd_data  (bridge_rd_data)
  );

  // write data and low address bits go to every peer
  settings_regs settings_i (
    .clk_74a                 (clk_74a),
    .pll_core_locked         (pll_core_locked),
    .cfg_wr                  (cfg_wr),
    .cfg_offset              (bridge_addr[CFG_OFFSET_W-1:0]),
    .wr_data                 (bridge_wr_data),
    .hide_overscan           (hide_overscan),
    .mask_vid_edges          (mask_vid_edges),
    .allow_extra_sprites     (allow_extra_sprites),
    .selected_palette        (selected_palette),
    .multitap_enabled        (multitap_enabled),
    .lightgun_enabled        (lightgun_enabled),
    .lightgun_dpad_aim_speed (lightgun_dpad_aim_speed),
    .swap_controllers        (swap_controllers),
    .external_reset          (external_reset)
  );

  save_buffer save_i (
    .clk_74a   (clk_74a),
    .save_wr   (save_wr),
    .save_rd   (save_rd),
    .word_addr (bridge_addr[SAVE_ADDR_W+1:2]),
    .wr_data   (bridge_wr_data),
    .save_q    (save_q)
  );

  ////////////////////////////////////////
  // video side
  video_condition video_i (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .h_blank         (h_blank),
    .v_blank         (v_blank),
    .hsync_in        (hsync_in),
    .vsync_in        (vsync_in),
    .rgb_in          (rgb_in),
    .hide_overscan   (hide_overscan),
    .video_de        (video_de),
    .video_hs        (video_hs),
    .video_vs        (video_vs),
    .video_rgb       (video_rgb)
  );

endmodule

// ==== verilog/video_condition.sv ====
// turns core blanking and sync into the scaler's video signals
// de, vs and rgb are registered one cycle after their inputs
// hs is a single pulse delayed after the core's hsync rising edge
// the first blanking cycle after active video carries the slot word

`timescale 1ns/10ps

module video_condition
  import pocket_pkg::*;
(
  input  logic             clk_74a,
  input  logic             pll_core_locked,
  input  logic             h_blank,
  input  logic             v_blank,
  input  logic             hsync_in,
  input  logic             vsync_in,
  input  logic [RGB_W-1:0] rgb_in,
  input  logic             hide_overscan,
  output logic             video_de,
  output logic             video_hs,
  output logic             video_vs,
  output logic [RGB_W-1:0] video_rgb
);

  logic                de;
  logic [RGB_W-1:0]    slot_word;
  logic                hs_prev;
  logic                vs_prev;
  logic                de_prev;
  logic [HS_CNT_W-1:0] hs_delay;

  assign de = ~(h_blank | v_blank);

  always_comb begin
    slot_word                    = '0;
    slot_word[SLOT_OVERSCAN_BIT] = hide_overscan;
  end

  ////////////////////////////////////////
  // output stage
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      video_rgb <= '0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
      de_prev   <= 1'b0;
      hs_delay  <= '0;
    end else begin
      video_de <= de;
      if (de) begin
        video_rgb <= rgb_in;
      end else if (de_prev) begin
        // first cycle of blanking
        video_rgb <= slot_word;
      end else begin
        video_rgb <= '0;
      end

      // hs fires as the delay runs out and a fresh edge restarts it
      video_hs <= (hs_delay == HS_CNT_W'(1));
      if (!hs_prev && hsync_in) begin
        hs_delay <= HS_CNT_W'(HS_DELAY);
      end else if (hs_delay != '0) begin
        hs_delay <= hs_delay - 1'b1;
      end

      video_vs <= !vs_prev && vsync_in;
      hs_prev  <= hsync_in;
      vs_prev  <= vsync_in;
      de_prev  <= de;
    end
  end

  a_vs_single_pulse : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    video_vs |=> !video_vs
  );

endmodule

// ==== verilog/save_buffer.sv ====
// word-wide save data buffer in the bridge save region
// written and read back by the host, one word per bridge access
// read data is registered and held until the next read

`timescale 1ns/10ps

module save_buffer
  import pocket_pkg::*;
(
  input  logic                   clk_74a,
  input  logic                   save_wr,
  input  logic                   save_rd,
  input  logic [SAVE_ADDR_W-1:0] word_addr,
  input  logic [BRIDGE_W-1:0]    wr_data,
  output logic [BRIDGE_W-1:0]    save_q
);

  logic [BRIDGE_W-1:0] mem [0:SAVE_WORDS-1];

  ////////////////////////////////////////
  // write port
  always_ff @(posedge clk_74a) begin
    if (save_wr) begin
      mem[word_addr] <= wr_data;
    end
  end

  // read port
  // only loads on a read strobe
  always_ff @(posedge clk_74a) begin
    if (save_rd) begin
      save_q <= mem[word_addr];
    end
  end

  // the decoder never asks for a read and a write at once
  a_no_save_rd_wr : assert property (
    @(posedge clk_74a)
    !(save_wr && save_rd)
  );

endmodule

// ==== verilog/settings_regs.sv ====
// config space setting registers written by the host
// each setting keeps only the low bits its width needs
// a write to the reset register starts the hold-off reset of the core

`timescale 1ns/10ps

module settings_regs
  import pocket_pkg::*;
(
  input  logic                    clk_74a,
  input  logic                    pll_core_locked,
  input  logic                    cfg_wr,
  input  logic [CFG_OFFSET_W-1:0] cfg_offset,
  input  logic [BRIDGE_W-1:0]     wr_data,
  output logic                    hide_overscan,
  output logic [EDGE_MASK_W-1:0]  mask_vid_edges,
  output logic                    allow_extra_sprites,
  output logic [PALETTE_W-1:0]    selected_palette,
  output logic                    multitap_enabled,
  output logic                    lightgun_enabled,
  output logic [AIM_SPEED_W-1:0]  lightgun_dpad_aim_speed,
  output logic                    swap_controllers,
  output logic                    external_reset
);

  cfg_reg_t               reg_sel;
  logic [RESET_CNT_W-1:0] reset_cnt;

  assign reg_sel = cfg_reg_t'(cfg_offset);

  ////////////////////////////////////////
  // settings
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hide_overscan           <= 1'b0;
      mask_vid_edges          <= '0;
      allow_extra_sprites     <= 1'b0;
      selected_palette        <= '0;
      multitap_enabled        <= 1'b0;
      lightgun_enabled        <= 1'b0;
      lightgun_dpad_aim_speed <= '0;
      swap_controllers        <= 1'b0;
    end else if (cfg_wr) begin
      case (reg_sel)
        REG_OVERSCAN:      hide_overscan           <= wr_data[0];
        REG_VID_EDGES:     mask_vid_edges          <= wr_data[EDGE_MASK_W-1:0];
        REG_EXTRA_SPRITES: allow_extra_sprites     <= wr_data[0];
        REG_PALETTE:       selected_palette        <= wr_data[PALETTE_W-1:0];
        REG_MULTITAP:      multitap_enabled        <= wr_data[0];
        REG_LIGHTGUN:      lightgun_enabled        <= wr_data[0];
        REG_AIM_SPEED:     lightgun_dpad_aim_speed <= wr_data[AIM_SPEED_W-1:0];
        REG_SWAP_CONT:     swap_controllers        <= wr_data[0];
        // reset register handled by the counter and other offsets ignored
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////
  // reset hold counter
  // reload on every write, so a new request extends the hold
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      reset_cnt <= '0;
    end else if (cfg_wr && reg_sel == REG_RESET) begin
      reset_cnt <= RESET_CNT_W'(RESET_HOLD_CYCLES);
    end else if (reset_cnt != '0) begin
      reset_cnt <= reset_cnt - 1'b1;
    end
  end

  assign external_reset = (reset_cnt != '0);

  a_reset_cnt_bound : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    reset_cnt <= RESET_CNT_W'(RESET_HOLD_CYCLES)
  );

endmodule

// ==== verilog/bridge_decode.sv ====
// bridge address decoder
// steers the host write and read strobes to the peer owning the region
// and muxes the read data back with a fixed one cycle latency

`timescale 1ns/10ps

module bridge_decode
  import pocket_pkg::*;
(
  input  logic                clk_74a,
  input  logic                pll_core_locked,
  input  logic [BRIDGE_W-1:0] bridge_addr,
  input  logic                bridge_rd,
  input  logic                bridge_wr,
  input  logic [BRIDGE_W-1:0] save_q,
  output logic                cfg_wr,
  output logic                save_wr,
  output logic                save_rd,
  output logic [BRIDGE_W-1:0] bridge_rd_data
);

  bridge_region_t region;
  logic           hit_cfg;
  logic           hit_save;
  // last read landed in the save region
  logic           rd_from_save;

  assign region   = bridge_region_t'(bridge_addr[BRIDGE_W-1 -: REGION_W]);
  assign hit_cfg  = (region == REGION_CFG);
  assign hit_save = (region == REGION_SAVE);

  ////////////////////////////////////////
  // per-peer strobes
  assign cfg_wr  = bridge_wr && hit_cfg;
  assign save_wr = bridge_wr && hit_save;
  assign save_rd = bridge_rd && hit_save;

  // selection only changes on a read strobe, so data holds between reads
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      rd_from_save <= 1'b0;
    end else if (bridge_rd) begin
      rd_from_save <= hit_save;
    end
  end

  // cfg and unmapped regions read back as zero
  assign bridge_rd_data = rd_from_save ? save_q : '0;

  // host never issues read and write in the same cycle
  a_no_rd_wr_overlap : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    !(bridge_rd && bridge_wr)
  );

endmodule

// ==== verilog/pocket_pkg.sv ====
// shared definitions for the bridge-facing part of the NES core top level
// region and config register encodings plus widths and timing constants
// imported by wildcard in the module headers that need them

package pocket_pkg;

  ////////////////////////////////////////
  // widths
  localparam int BRIDGE_W     = 32;
  localparam int REGION_W     = 4;
  localparam int CFG_OFFSET_W = 12;
  localparam int SAVE_ADDR_W  = 8;
  localparam int SAVE_WORDS   = 2 ** SAVE_ADDR_W;
  localparam int RGB_W        = 24;
  localparam int PALETTE_W    = 3;
  localparam int EDGE_MASK_W  = 2;
  localparam int AIM_SPEED_W  = 8;

  ////////////////////////////////////////
  // timing
  localparam int RESET_HOLD_CYCLES = 1048576;
  localparam int RESET_CNT_W       = $clog2(RESET_HOLD_CYCLES + 1);
  localparam int HS_DELAY          = 7;
  localparam int HS_CNT_W          = $clog2(HS_DELAY + 1);
  // slot word bit carrying the overscan flag to the scaler
  localparam int SLOT_OVERSCAN_BIT = 13;

  // upper address nibble values that map to a peer
  typedef enum logic [REGION_W-1:0] {
    REGION_CFG  = 4'h0,
    REGION_SAVE = 4'h2
  } bridge_region_t;

  typedef enum logic [CFG_OFFSET_W-1:0] {
    REG_RESET         = 12'h050,
    REG_OVERSCAN      = 12'h200,
    REG_VID_EDGES     = 12'h204,
    REG_EXTRA_SPRITES = 12'h208,
    REG_PALETTE       = 12'h20C,
    REG_MULTITAP      = 12'h300,
    REG_LIGHTGUN      = 12'h304,
    REG_AIM_SPEED     = 12'h308,
    REG_SWAP_CONT     = 12'h30C
  } cfg_reg_t;

endpackage
